/* design/sramPkg.sv */
`default_nettype none

package sramPkg;

	// Port and bus sizing
	localparam int numPorts = 4; // Requesters on the board side
	localparam int portIdxW = 2; // Enough bits to name one port
	localparam int addrW = 20; // SRAM address lines
	localparam int dataW = 16; // SRAM data lines

	// Request FIFO sizing
	localparam int fifoPtrW = 3; // Index bits into the FIFO storage
	localparam int fifoDepth = 8; // Entries per port, must equal 2**fifoPtrW

	// One queued request, as it sits in a port FIFO
	typedef struct packed {
		logic isWrite; // High for a write, low for a read
		logic [addrW-1:0] addr; // Target word
		logic [dataW-1:0] wdata; // Write payload, unused on reads
	} memReq_t;

	// Registered outputs toward the SRAM chip
	// Chip enable and byte lanes are tied low on the board
	typedef struct packed {
		logic [addrW-1:0] addr; // Address bus
		logic oeN; // Output enable, active low
		logic weN; // Write enable, active low
		logic [dataW-1:0] dqOut; // Data driven onto the bus during a write
	} sramPins_t;

endpackage

`default_nettype wire

/* design/reqFifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Dual-clock request queue for one requester port
// Writes on the board clock, reads on the SRAM clock
module reqFifo (
	input logic wrClk, // Requester clock
	input logic rdClk, // Scheduler clock
	input logic arstN,
	input logic push, // One-cycle strobe, ignored while full
	input sramPkg::memReq_t din,
	output logic full, // Registered, valid in the wrClk domain
	input logic pop, // One-cycle strobe, ignored while empty
	output sramPkg::memReq_t dout, // Head entry, valid while not empty
	output logic empty // Valid in the rdClk domain
);

	sramPkg::memReq_t mem [sramPkg::fifoDepth]; // Request storage

	// Write side pointers, extra top bit tells wraps apart
	logic [sramPkg::fifoPtrW:0] wrBin;
	logic [sramPkg::fifoPtrW:0] wrBinNext;
	logic [sramPkg::fifoPtrW:0] wrGray;
	logic [sramPkg::fifoPtrW:0] wrGrayNext;

	// Read side pointers
	logic [sramPkg::fifoPtrW:0] rdBin;
	logic [sramPkg::fifoPtrW:0] rdBinNext;
	logic [sramPkg::fifoPtrW:0] rdGray;
	logic [sramPkg::fifoPtrW:0] rdGrayNext;

	// Crossing registers
	logic [sramPkg::fifoPtrW:0] rdGraySync1; // rdGray in wrClk, first stage
	logic [sramPkg::fifoPtrW:0] rdGraySync2; // rdGray in wrClk, stable copy
	logic [sramPkg::fifoPtrW:0] wrGraySync1; // wrGray in rdClk, first stage
	logic [sramPkg::fifoPtrW:0] wrGraySync2; // wrGray in rdClk, stable copy

	logic wrEn; // Accepted push
	logic rdEn; // Accepted pop
	logic fullNext;

	assign wrEn = push & ~full; // A strobe while full is dropped
	assign rdEn = pop & ~empty;

	assign wrBinNext = wrBin + {{sramPkg::fifoPtrW{1'b0}}, wrEn};
	assign wrGrayNext = (wrBinNext >> 1) ^ wrBinNext; // Binary to Gray
	assign rdBinNext = rdBin + {{sramPkg::fifoPtrW{1'b0}}, rdEn};
	assign rdGrayNext = (rdBinNext >> 1) ^ rdBinNext;

	// Full when the write pointer has lapped the read pointer once
	// In Gray code that means the two top bits differ and the rest match
	assign fullNext = (wrGrayNext == {~rdGraySync2[sramPkg::fifoPtrW -: 2],
		rdGraySync2[sramPkg::fifoPtrW-2:0]});

	// Storage write, data only
	always_ff @(posedge wrClk) begin
		if (wrEn) begin
			mem[wrBin[sramPkg::fifoPtrW-1:0]] <= din; // Low bits index the array
		end
	end

	// Write domain control
	always_ff @(posedge wrClk or negedge arstN) begin
		if (!arstN) begin
			wrBin <= '0;
			wrGray <= '0;
			full <= 1'b0;
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end else begin
			wrBin <= wrBinNext;
			wrGray <= wrGrayNext; // Only one bit changes per push
			full <= fullNext; // Reflects this edge's push from the next edge on
			rdGraySync1 <= rdGray; // Two-flop synchronizer
			rdGraySync2 <= rdGraySync1;
		end
	end

	// Read domain control
	always_ff @(posedge rdClk or negedge arstN) begin
		if (!arstN) begin
			rdBin <= '0;
			rdGray <= '0;
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end else begin
			rdBin <= rdBinNext; // Head advances at the edge after a pop
			rdGray <= rdGrayNext;
			wrGraySync1 <= wrGray; // Two-flop synchronizer
			wrGraySync2 <= wrGraySync1;
		end
	end

	// Empty compares against the synchronized write pointer
	// so it can only be late, never early
	assign empty = (rdGray == wrGraySync2);

	// Head entry straight from storage
	assign dout = mem[rdBin[sramPkg::fifoPtrW-1:0]];

endmodule

`default_nettype wire

/* design/sramScheduler.sv */
`timescale 1ns/1ps
`default_nettype none

// Serves the port FIFOs in round-robin order, one request per cycle
// Drives the SRAM pins from registers and hands read data back per port
module sramScheduler (
	input logic SRAM_CLK,
	input logic arstN,
	input sramPkg::memReq_t fifoReq [sramPkg::numPorts], // Head of each FIFO
	input logic [sramPkg::numPorts-1:0] fifoEmpty,
	output logic [sramPkg::numPorts-1:0] fifoPop, // One-hot, removes the head
	output sramPkg::sramPins_t pins, // Registered SRAM outputs
	output logic dqOe, // High while a write drives the data bus
	input logic [sramPkg::dataW-1:0] dqIn, // Data bus as seen at the pad
	output logic [sramPkg::dataW-1:0] rdData [sramPkg::numPorts],
	output logic [sramPkg::numPorts-1:0] rdReady // One-cycle pulse per read
);

	logic [sramPkg::portIdxW-1:0] rrPtr; // Last port served
	logic [sramPkg::portIdxW-1:0] selPort; // Port chosen this cycle
	logic selValid; // Something to issue this cycle
	sramPkg::memReq_t selReq; // Request at the chosen head

	// Issue stage registers, feed the pins
	logic [sramPkg::addrW-1:0] addrQ;
	logic [sramPkg::dataW-1:0] dqOutQ;
	logic oeNQ;
	logic weNQ;

	// Capture stage for the read issued last cycle
	logic capValid; // A read is on the bus this cycle
	logic [sramPkg::portIdxW-1:0] capPort; // Owner of that read

	// Round-robin search
	// Walks forward from the port after rrPtr and wraps back to rrPtr itself
	// so a lone busy port is still served every cycle
	always_comb begin
		logic [sramPkg::portIdxW-1:0] cand;
		cand = rrPtr;
		selValid = 1'b0;
		selPort = rrPtr;
		for (int k = 0; k < sramPkg::numPorts; k++) begin
			cand = cand + 1'b1; // Wraps at numPorts
			if (!selValid && !fifoEmpty[cand]) begin
				selValid = 1'b1; // First non-empty one wins
				selPort = cand;
			end
		end
	end

	assign selReq = fifoReq[selPort];

	// Pop the chosen FIFO in the same cycle it is selected
	always_comb begin
		fifoPop = '0;
		if (selValid) begin
			fifoPop[selPort] = 1'b1;
		end
	end

	// Issue control and capture bookkeeping
	always_ff @(posedge SRAM_CLK or negedge arstN) begin
		if (!arstN) begin
			rrPtr <= '0;
			oeNQ <= 1'b1; // Bus idle after reset
			weNQ <= 1'b1;
			dqOe <= 1'b0;
			capValid <= 1'b0;
			capPort <= '0;
			rdReady <= '0;
		end else begin
			if (selValid) begin
				rrPtr <= selPort; // Next search starts after this one
			end
			oeNQ <= ~(selValid & ~selReq.isWrite); // Low for one cycle per read
			weNQ <= ~(selValid & selReq.isWrite); // Low for one cycle per write
			dqOe <= selValid & selReq.isWrite; // Drive the bus only during a write
			capValid <= selValid & ~selReq.isWrite; // Read result due next edge
			capPort <= selPort;
			rdReady <= '0; // Pulses last exactly one cycle
			if (capValid) begin
				rdReady[capPort] <= 1'b1;
			end
		end
	end

	// Address and write data follow the selection
	// Their value while the strobes are high is all that matters
	always_ff @(posedge SRAM_CLK) begin
		addrQ <= selReq.addr;
		dqOutQ <= selReq.wdata;
	end

	// Read data capture, one edge after OE went low
	always_ff @(posedge SRAM_CLK) begin
		if (capValid) begin
			rdData[capPort] <= dqIn; // Other ports keep their last value
		end
	end

	// Pack the pin registers for the top level
	assign pins.addr = addrQ;
	assign pins.oeN = oeNQ;
	assign pins.weN = weNQ;
	assign pins.dqOut = dqOutQ;

endmodule

`default_nettype wire

/* design/sramController.sv */
`timescale 1ns/1ps
`default_nettype none

// Four-port SRAM controller
// Requests come in on BOARD_CLK, the SRAM runs on SRAM_CLK
// Read data and its ready pulse stay on SRAM_CLK
module sramController (
	input logic SRAM_CLK, // Memory side clock, the faster one
	input logic BOARD_CLK, // Requester side clock
	input logic arstN,
	input logic [sramPkg::numPorts-1:0] reqValid, // One strobe per request
	input sramPkg::memReq_t reqIn [sramPkg::numPorts],
	output logic [sramPkg::numPorts-1:0] reqFull, // Hold off strobes while high
	output logic [sramPkg::dataW-1:0] rdData [sramPkg::numPorts],
	output logic [sramPkg::numPorts-1:0] rdReady,
	output logic [sramPkg::addrW-1:0] sramAddr,
	output logic sramOeN,
	output logic sramWeN,
	inout wire [sramPkg::dataW-1:0] sramDq // Shared data bus
);

	sramPkg::memReq_t fifoReq [sramPkg::numPorts]; // FIFO heads
	logic [sramPkg::numPorts-1:0] fifoEmpty;
	logic [sramPkg::numPorts-1:0] fifoPop;
	sramPkg::sramPins_t pins; // Registered pin values from the scheduler
	logic dqOe;

	// One clock-crossing queue per requester
	for (genvar i = 0; i < sramPkg::numPorts; i++) begin : genFifo
		reqFifo uFifo (
			.wrClk(BOARD_CLK),
			.rdClk(SRAM_CLK),
			.arstN(arstN),
			.push(reqValid[i]),
			.din(reqIn[i]),
			.full(reqFull[i]),
			.pop(fifoPop[i]),
			.dout(fifoReq[i]),
			.empty(fifoEmpty[i])
		);
	end

	sramScheduler uScheduler (
		.SRAM_CLK(SRAM_CLK),
		.arstN(arstN),
		.fifoReq(fifoReq),
		.fifoEmpty(fifoEmpty),
		.fifoPop(fifoPop),
		.pins(pins),
		.dqOe(dqOe),
		.dqIn(sramDq), // Read back from the pad
		.rdData(rdData),
		.rdReady(rdReady)
	);

	assign sramAddr = pins.addr;
	assign sramOeN = pins.oeN;
	assign sramWeN = pins.weN;

	// Tri-state pad, released whenever no write is in progress
	assign sramDq = dqOe ? pins.dqOut : {sramPkg::dataW{1'bz}};

endmodule

`default_nettype wire

/* verif/sramModel.sv */
`timescale 1ns/1ps
`default_nettype none

// Behavioral asynchronous SRAM, one word per address
// Words never written read back a fixed pattern of their address
module sramModel (
	input logic [sramPkg::addrW-1:0] addr,
	input logic oeN, // Output enable, active low
	input logic weN, // Write enable, active low, wins over oeN
	inout wire [sramPkg::dataW-1:0] dq // Shared data bus
);

	logic [sramPkg::dataW-1:0] mem [logic [sramPkg::addrW-1:0]]; // Only written words
	logic [sramPkg::dataW-1:0] rdWord; // Word at the current address

	// Preset content, upper address bits folded into the top nibble
	function automatic logic [sramPkg::dataW-1:0] fillWord(input logic [sramPkg::addrW-1:0] a);
		return a[sramPkg::dataW-1:0] ^ {a[sramPkg::addrW-1:sramPkg::dataW], 12'h000} ^ 16'hA5A5;
	endfunction

	// Address, data and strobe of one clock edge land in the same time step
	// Storing 1 ns later sees them all settled
	always @(weN or addr or dq) begin
		#1;
		if (!weN) begin
			mem[addr] = dq; // Level write while the strobe is low
		end
	end

	// Strobe edges also retrigger, so a read right after a write sees new data
	always @(addr or oeN or weN) begin
		rdWord = mem.exists(addr) ? mem[addr] : fillWord(addr);
	end

	assign dq = (!oeN && weN) ? rdWord : {sramPkg::dataW{1'bz}}; // Drive only on reads

endmodule

`default_nettype wire

/* verif/tbSramController.sv */
`timescale 1ns/1ps
`default_nettype none

module tbSramController;

	localparam int boardPeriod = 20; // ns
	localparam int sramPeriod = 10; // ns
	localparam int totalReqs = 36 + 96 + 24 + 160; // Requests over all tests
	localparam int watchdogNs = totalReqs * 40 * boardPeriod;
	localparam int drainCycles = 100; // BOARD_CLK cycles for the last reads to return

	logic BOARD_CLK;
	logic SRAM_CLK;
	logic arstN;
	logic [sramPkg::numPorts-1:0] reqValid;
	sramPkg::memReq_t reqIn [sramPkg::numPorts];
	logic [sramPkg::numPorts-1:0] reqFull;
	logic [sramPkg::dataW-1:0] rdData [sramPkg::numPorts];
	logic [sramPkg::numPorts-1:0] rdReady;
	logic [sramPkg::addrW-1:0] sramAddr;
	logic sramOeN;
	logic sramWeN;
	wire [sramPkg::dataW-1:0] sramDq;

	logic [31:0] lfsrState = 32'h10f6_a25a; // Stimulus source
	logic [sramPkg::dataW-1:0] shadow [logic [sramPkg::addrW-1:0]]; // Words written so far
	logic [sramPkg::dataW-1:0] expQ [sramPkg::numPorts][$]; // Pending reads per port
	int strobeCnt [sramPkg::numPorts]; // Read strobes sent
	int readyCnt [sramPkg::numPorts]; // rdReady pulses seen
	logic [sramPkg::numPorts-1:0] sawFull; // Port had to wait on reqFull
	logic fairMode = 1'b0; // Round-robin order check enabled
	string testName = "idle";

	sramController dut (
		.SRAM_CLK(SRAM_CLK),
		.BOARD_CLK(BOARD_CLK),
		.arstN(arstN),
		.reqValid(reqValid),
		.reqIn(reqIn),
		.reqFull(reqFull),
		.rdData(rdData),
		.rdReady(rdReady),
		.sramAddr(sramAddr),
		.sramOeN(sramOeN),
		.sramWeN(sramWeN),
		.sramDq(sramDq)
	);

	sramModel uSram (
		.addr(sramAddr),
		.oeN(sramOeN),
		.weN(sramWeN),
		.dq(sramDq)
	);

	initial begin
		BOARD_CLK = 1'b0;
		forever #(boardPeriod / 2) BOARD_CLK = ~BOARD_CLK;
	end

	initial begin
		SRAM_CLK = 1'b0;
		forever #(sramPeriod / 2) SRAM_CLK = ~SRAM_CLK;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal) begin
			failRun($sformatf("ERR %s expected %h actual %h", name, expVal, actVal));
		end
	endtask

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsrState[0]}; // One step per bit
			lfsrState = lfsrStep(lfsrState);
		end
		return r;
	endfunction

	// Memory content before any write with the upper address nibble in the top bits
	function automatic logic [sramPkg::dataW-1:0] patternOf(input logic [sramPkg::addrW-1:0] a);
		logic [3:0] hi;
		hi = a[19:16];
		return a[15:0] ^ {hi, 12'h000} ^ 16'hA5A5;
	endfunction

	function automatic logic [sramPkg::dataW-1:0] expectedRead(input logic [sramPkg::addrW-1:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return patternOf(a);
	endfunction

	function automatic logic anyPending();
		logic busy;
		busy = 1'b0;
		for (int p = 0; p < sramPkg::numPorts; p++) begin
			busy |= (expQ[p].size() != 0);
		end
		return busy;
	endfunction

	task automatic clearCounts();
		for (int p = 0; p < sramPkg::numPorts; p++) begin
			strobeCnt[p] = 0;
			readyCnt[p] = 0;
		end
		sawFull = '0;
	endtask

	// Called on a falling BOARD_CLK edge and returns on the next one
	// Back-to-back calls give strobes on consecutive cycles
	task automatic sendReq(input int port, input logic isWrite,
		input logic [sramPkg::addrW-1:0] addr, input logic [sramPkg::dataW-1:0] data);
		while (reqFull[port]) begin
			sawFull[port] = 1'b1; // Hold off until the FIFO drains
			@(negedge BOARD_CLK);
		end
		reqIn[port].isWrite = isWrite;
		reqIn[port].addr = addr;
		reqIn[port].wdata = data;
		reqValid[port] = 1'b1;
		if (isWrite) begin
			shadow[addr] = data;
		end else begin
			expQ[port].push_back(expectedRead(addr));
			strobeCnt[port]++;
		end
		@(negedge BOARD_CLK);
		reqValid[port] = 1'b0;
	endtask

	// Random reads and writes inside the port's own quarter of the address space
	// The last request is always a read, so its return means all writes landed
	task automatic mixedTraffic(input int port, input int n);
		logic [sramPkg::addrW-1:0] written [$];
		logic [sramPkg::addrW-1:0] addr;
		logic [sramPkg::dataW-1:0] data;
		logic doWrite;
		for (int k = 0; k < n; k++) begin
			doWrite = randBits(1);
			addr = randBits(sramPkg::addrW - sramPkg::portIdxW);
			addr[sramPkg::addrW-1 -: sramPkg::portIdxW] = port; // Disjoint ranges
			data = randBits(sramPkg::dataW);
			if (k == n - 1) begin
				doWrite = 1'b0;
			end
			if (!doWrite && written.size() != 0 && randBits(1)) begin
				addr = written[randBits(4) % written.size()]; // Read back own write
			end
			sendReq(port, doWrite, addr, data);
			if (doWrite) begin
				written.push_back(addr);
			end
		end
	endtask

	task automatic readBurst(input int port, input int n);
		for (int k = 0; k < n; k++) begin
			sendReq(port, 1'b0, randBits(sramPkg::addrW), '0);
		end
	endtask

	// Waits for every queued read to return or for drainCycles to pass
	task automatic waitDrain();
		int waited;
		waited = 0;
		while (anyPending() && waited < drainCycles) begin
			@(negedge BOARD_CLK);
			waited++;
		end
	endtask

	// Response checker samples mid cycle where rdReady and rdData are steady
	always @(negedge SRAM_CLK) begin
		logic [sramPkg::dataW-1:0] expWord;
		for (int p = 0; p < sramPkg::numPorts; p++) begin
			if (rdReady[p] === 1'b1) begin
				if (expQ[p].size() == 0) begin
					failRun($sformatf("Port %0d returned read data nobody asked for", p));
				end else begin
					if (fairMode && readyCnt[p] > 0) begin
						for (int q = 0; q < sramPkg::numPorts; q++) begin
							if (q != p && readyCnt[q] == 0) begin
								failRun($sformatf("Port %0d served twice before port %0d", p, q));
							end
						end
					end
					expWord = expQ[p].pop_front(); // Oldest read of this port
					readyCnt[p]++;
					checkEq($sformatf("%s rdData port %0d", testName, p), expWord, rdData[p]);
				end
			end
		end
	end

	initial begin
		#(watchdogNs);
		failRun("Timeout, the requests did not all complete in time");
	end

	initial begin
		logic [sramPkg::addrW-1:0] addrList [16];
		logic [sramPkg::dataW-1:0] dataList [16];
		logic [sramPkg::addrW-1:0] addr;
		arstN = 1'b0;
		reqValid = '0;
		for (int p = 0; p < sramPkg::numPorts; p++) begin
			reqIn[p] = '0;
		end
		clearCounts();
		repeat (5) @(negedge BOARD_CLK);
		arstN = 1'b1;
		@(negedge BOARD_CLK);

		testName = "reset";
		checkEq("reset sramOeN", 1, sramOeN);
		checkEq("reset sramWeN", 1, sramWeN);
		checkEq("reset rdReady", 0, rdReady);
		checkEq("reset reqFull", 0, reqFull);

		testName = "single port";
		for (int k = 0; k < 16; k++) begin
			addrList[k] = randBits(sramPkg::addrW);
			dataList[k] = randBits(sramPkg::dataW);
			sendReq(0, 1'b1, addrList[k], dataList[k]);
		end
		for (int k = 0; k < 16; k++) begin
			sendReq(0, 1'b0, addrList[k], '0);
		end
		for (int k = 0; k < 4; k++) begin
			addr = randBits(sramPkg::addrW);
			while (shadow.exists(addr)) begin
				addr = randBits(sramPkg::addrW);
			end
			sendReq(0, 1'b0, addr, '0); // Never written so the pattern is expected
		end
		waitDrain();

		testName = "four ports mixed";
		fork
			mixedTraffic(0, 24);
			mixedTraffic(1, 24);
			mixedTraffic(2, 24);
			mixedTraffic(3, 24);
		join
		waitDrain();

		testName = "fairness";
		clearCounts();
		fairMode = 1'b1;
		fork
			readBurst(0, 6);
			readBurst(1, 6);
			readBurst(2, 6);
			readBurst(3, 6);
		join
		waitDrain();
		fairMode = 1'b0;

		// Port 1 is the one under test while the others load the scheduler
		// so its FIFO fills faster than it drains
		testName = "back-pressure";
		clearCounts();
		fork
			readBurst(0, 40);
			readBurst(1, 40);
			readBurst(2, 40);
			readBurst(3, 40);
		join
		waitDrain();
		for (int p = 0; p < sramPkg::numPorts; p++) begin
			checkEq($sformatf("back-pressure count port %0d", p), strobeCnt[p], readyCnt[p]);
		end
		checkEq("back-pressure reqFull seen on port 1", 1, sawFull[1]);

		repeat (8) @(negedge BOARD_CLK); // Quiet tail where a stray rdReady still gets flagged
		if (anyPending()) begin
			failRun("Read responses still outstanding at the end of the run");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
design/sramPkg.sv
design/reqFifo.sv
design/sramScheduler.sv
design/sramController.sv
verif/sramModel.sv
verif/tbSramController.sv

/* Bender.yml */
package:
  name: sramController

sources:
  - files:
      - design/sramPkg.sv
      - design/reqFifo.sv
      - design/sramScheduler.sv
      - design/sramController.sv
  - target: test
    files:
      - verif/sramModel.sv
      - verif/tbSramController.sv
